/* source/mem_pkg.sv */
package mem_pkg;

	//////////////////////////////////////////////////
	// Memory geometry
	//////////////////////////////////////////////////

	// Word address into the data array
	localparam int mem_addr_w = 14;

	// One memory word
	localparam int mem_data_w = 64;

	// Number of words in the array
	localparam int mem_depth = 16384;

	//////////////////////////////////////////////////
	// Fetch view
	//////////////////////////////////////////////////

	// One instruction is half a memory word
	localparam int instr_w = 32;

	// Word address plus one half-select bit at bit 0
	localparam int fetch_addr_w = mem_addr_w + 1;

	//////////////////////////////////////////////////
	// Access timing
	//////////////////////////////////////////////////

	// Cycles spent in WAIT for every access
	localparam int mem_wait_cycles = 4;

	// Counter only has to reach mem_wait_cycles - 1
	localparam int wait_cnt_w = $clog2(mem_wait_cycles);

	// Returned word seen as a doubleword or as two instructions
	// instr[0] is the low half
	typedef union packed {
		logic [mem_data_w-1:0]   dword;
		logic [1:0][instr_w-1:0] instr;
	} mem_word_u;

endpackage

/* source/data_memory.sv */
module data_memory (
	input  logic                          clk,
	input  logic                          en,
	input  logic                          we,
	input  logic [mem_pkg::mem_addr_w-1:0] addr,
	input  logic [mem_pkg::mem_data_w-1:0] wdata,
	output logic [mem_pkg::mem_data_w-1:0] rdata
);

	import mem_pkg::*;

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	// Single-ported array, maps onto block RAM
	logic [mem_data_w-1:0] ram [mem_depth];

	//////////////////////////////////////////////////
	// Read-first port
	//////////////////////////////////////////////////

	// Old word comes out even on a write
	// Output register only moves when enabled
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= ram[addr];
			// Update after the old word has been sampled
			if (we) begin
				ram[addr] <= wdata;
			end
		end
	end

endmodule

/* source/memory_interface.sv */
module memory_interface (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	output logic                          req_ready,
	input  logic                          req_write,
	input  logic [mem_pkg::mem_addr_w-1:0] req_addr,
	input  logic [mem_pkg::mem_data_w-1:0] req_wdata,
	output logic                          rsp_done,
	output logic [mem_pkg::mem_data_w-1:0] rsp_data
);

	import mem_pkg::*;

	// Access states
	localparam logic [1:0] st_idle = 2'b00;
	localparam logic [1:0] st_wait = 2'b01;
	localparam logic [1:0] st_read = 2'b10;
	localparam logic [1:0] st_done = 2'b11;

	logic [1:0]            state;
	logic [1:0]            nxt_state;
	logic [wait_cnt_w-1:0] cntr;
	logic                  cntr_clr;
	logic                  cntr_enable;
	logic                  time_up;
	logic                  load;
	logic                  accept;
	logic [mem_data_w-1:0] stored_data;

	// Memory side
	logic                  mem_en;
	logic                  mem_we;
	logic [mem_addr_w-1:0] mem_addr;
	logic [mem_data_w-1:0] mem_wdata;
	logic [mem_data_w-1:0] mem_rdata;

	//////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////

	// Only one access in flight
	assign req_ready = (state == st_idle);
	assign accept    = req_valid && req_ready;

	// Array is driven straight from the request in the accept cycle
	assign mem_en    = accept;
	assign mem_we    = accept && req_write;
	assign mem_addr  = req_addr;
	assign mem_wdata = req_wdata;

	//////////////////////////////////////////////////
	// State and wait counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			state <= nxt_state;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cntr <= '0;
		end else if (cntr_clr) begin
			cntr <= '0;
		end else if (cntr_enable) begin
			cntr <= cntr + 1'b1;
		end
	end

	// Last WAIT cycle
	assign time_up = (cntr == wait_cnt_w'(mem_wait_cycles - 1));

	// Read word held from READ until DONE
	always_ff @(posedge clk) begin
		if (load) begin
			stored_data <= mem_rdata;
		end
	end

	always_comb begin
		nxt_state   = state;
		cntr_clr    = 1'b0;
		cntr_enable = 1'b0;
		load        = 1'b0;
		case (state)
			st_idle: begin
				// Writes also pass READ to return the old word
				if (accept) begin
					nxt_state = st_read;
				end
			end
			st_read: begin
				load      = 1'b1;
				nxt_state = st_wait;
			end
			st_wait: begin
				if (time_up) begin
					nxt_state = st_done;
				end else begin
					cntr_enable = 1'b1;
				end
			end
			default: begin
				// DONE pulses for one cycle and rearms the counter
				cntr_clr  = 1'b1;
				nxt_state = st_idle;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Response
	//////////////////////////////////////////////////

	assign rsp_done = (state == st_done);
	// Zero outside the done cycle
	assign rsp_data = rsp_done ? stored_data : '0;

	data_memory u_data_memory (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

/* source/port_arbiter.sv */
module port_arbiter (
	input  logic                            clk,
	input  logic                            rst,
	// Fetch client
	input  logic                            fetch_valid,
	input  logic [mem_pkg::fetch_addr_w-1:0] fetch_addr,
	output logic                            fetch_ready,
	output logic                            fetch_done,
	output logic [mem_pkg::instr_w-1:0]      fetch_instr,
	// Load/store client
	input  logic                            ls_valid,
	input  logic                            ls_write,
	input  logic [mem_pkg::mem_addr_w-1:0]   ls_addr,
	input  logic [mem_pkg::mem_data_w-1:0]   ls_wdata,
	output logic                            ls_ready,
	output logic                            ls_done,
	output logic [mem_pkg::mem_data_w-1:0]   ls_rdata,
	// Toward memory_interface
	output logic                            req_valid,
	input  logic                            req_ready,
	output logic                            req_write,
	output logic [mem_pkg::mem_addr_w-1:0]   req_addr,
	output logic [mem_pkg::mem_data_w-1:0]   req_wdata,
	input  logic                            rsp_done,
	input  logic [mem_pkg::mem_data_w-1:0]   rsp_data
);

	import mem_pkg::*;

	// Fetch wins the next tie when set
	logic      prio_fetch;
	logic      sel_fetch;
	logic      accept;
	// Owner of the access in flight
	logic      owner_fetch;
	logic      half_sel;
	mem_word_u rsp_word;

	//////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////

	// Fetch takes the port when alone or when it holds priority
	// With no request pending the load/store side is selected
	assign sel_fetch = fetch_valid && (prio_fetch || !ls_valid);

	assign req_valid = fetch_valid || ls_valid;
	assign accept    = req_valid && req_ready;

	// Ready goes only to the selected client
	assign fetch_ready = req_ready && sel_fetch;
	assign ls_ready    = req_ready && !sel_fetch;

	// Fetch is read only
	assign req_write = sel_fetch ? 1'b0 : ls_write;
	// Upper bits of the fetch address pick the word
	assign req_addr  = sel_fetch ? fetch_addr[fetch_addr_w-1:1] : ls_addr;
	assign req_wdata = sel_fetch ? '0 : ls_wdata;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			// Load/store first after reset
			prio_fetch  <= 1'b0;
			owner_fetch <= 1'b0;
			half_sel    <= 1'b0;
		end else if (accept) begin
			// Loser of this grant goes first next time
			prio_fetch  <= !sel_fetch;
			owner_fetch <= sel_fetch;
			half_sel    <= fetch_addr[0];
		end
	end

	//////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////

	assign rsp_word.dword = rsp_data;

	// Done goes to the owner in the same cycle
	assign fetch_done = rsp_done && owner_fetch;
	assign ls_done    = rsp_done && !owner_fetch;

	// Half-select picks one instruction out of the word
	assign fetch_instr = fetch_done ? rsp_word.instr[half_sel] : '0;
	assign ls_rdata    = ls_done ? rsp_word.dword : '0;

endmodule

/* source/mem_subsystem.sv */
module mem_subsystem (
	input  logic                            clk,
	input  logic                            rst,
	// Fetch client
	input  logic                            fetch_valid,
	input  logic [mem_pkg::fetch_addr_w-1:0] fetch_addr,
	output logic                            fetch_ready,
	output logic                            fetch_done,
	output logic [mem_pkg::instr_w-1:0]      fetch_instr,
	// Load/store client
	input  logic                            ls_valid,
	input  logic                            ls_write,
	input  logic [mem_pkg::mem_addr_w-1:0]   ls_addr,
	input  logic [mem_pkg::mem_data_w-1:0]   ls_wdata,
	output logic                            ls_ready,
	output logic                            ls_done,
	output logic [mem_pkg::mem_data_w-1:0]   ls_rdata
);

	import mem_pkg::*;

	//////////////////////////////////////////////////
	// Arbiter to interface
	//////////////////////////////////////////////////

	logic                  req_valid;
	logic                  req_ready;
	logic                  req_write;
	logic [mem_addr_w-1:0] req_addr;
	logic [mem_data_w-1:0] req_wdata;
	logic                  rsp_done;
	logic [mem_data_w-1:0] rsp_data;

	port_arbiter u_port_arbiter (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.fetch_done  (fetch_done),
		.fetch_instr (fetch_instr),
		.ls_valid    (ls_valid),
		.ls_write    (ls_write),
		.ls_addr     (ls_addr),
		.ls_wdata    (ls_wdata),
		.ls_ready    (ls_ready),
		.ls_done     (ls_done),
		.ls_rdata    (ls_rdata),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.rsp_done    (rsp_done),
		.rsp_data    (rsp_data)
	);

	// Access sequencing and the array
	memory_interface u_memory_interface (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_done  (rsp_done),
		.rsp_data  (rsp_data)
	);

endmodule

/* verif/mem_subsystem_properties.sv */
module mem_subsystem_properties (
	input logic                           clk,
	input logic                           rst,
	input logic                           req_valid,
	input logic                           req_ready,
	input logic                           rsp_done,
	input logic                           fetch_done,
	input logic [mem_pkg::instr_w-1:0]    fetch_instr,
	input logic                           ls_done,
	input logic [mem_pkg::mem_data_w-1:0] ls_rdata
);

	logic accept;
	logic any_done;

	assign accept   = req_valid && req_ready;
	assign any_done = rsp_done || fetch_done || ls_done;

	//////////////////////////////////////////////////
	// Response timing
	//////////////////////////////////////////////////

	// Single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		any_done |=> !any_done)
		else $error("done stayed high for more than one cycle");

	// READ, four WAIT cycles, then DONE
	done_latency: assert property (@(posedge clk) disable iff (!rst)
		accept |=> !rsp_done ##1 !rsp_done ##1 !rsp_done ##1 !rsp_done ##1 !rsp_done
		##1 rsp_done)
		else $error("done did not arrive six cycles after acceptance");

	busy_not_ready: assert property (@(posedge clk) disable iff (!rst)
		accept |=> !req_ready ##1 !req_ready ##1 !req_ready ##1 !req_ready ##1 !req_ready
		##1 !req_ready)
		else $error("req_ready rose before the access completed");

	//////////////////////////////////////////////////
	// Client outputs
	//////////////////////////////////////////////////

	one_client_done: assert property (@(posedge clk) disable iff (!rst)
		!(fetch_done && ls_done))
		else $error("both client done outputs high together");

	fetch_data_zero: assert property (@(posedge clk) disable iff (!rst)
		!fetch_done |-> fetch_instr == '0)
		else $error("fetch_instr nonzero outside its done cycle");

	ls_data_zero: assert property (@(posedge clk) disable iff (!rst)
		!ls_done |-> ls_rdata == '0)
		else $error("ls_rdata nonzero outside its done cycle");

	// Quiet in reset
	reset_quiet: assert property (@(posedge clk)
		!rst |-> !any_done && !accept && fetch_instr == '0 && ls_rdata == '0)
		else $error("activity seen while reset is asserted");

endmodule

/* verif/mem_subsystem_tb.sv */
module mem_subsystem_tb;

	import mem_pkg::*;

	// Reset plus write/read, old-word, fetch, contention and random accesses
	localparam int reset_cycles = 5;
	localparam int num_accesses = 16 + 8 + 16 + 16 + 40;
	localparam int cycle_limit  = 200 * num_accesses + reset_cycles;

	logic                    clk;
	logic                    rst;
	logic                    fetch_valid;
	logic [fetch_addr_w-1:0] fetch_addr;
	logic                    fetch_ready;
	logic                    fetch_done;
	logic [instr_w-1:0]      fetch_instr;
	logic                    ls_valid;
	logic                    ls_write;
	logic [mem_addr_w-1:0]   ls_addr;
	logic [mem_data_w-1:0]   ls_wdata;
	logic                    ls_ready;
	logic                    ls_done;
	logic [mem_data_w-1:0]   ls_rdata;

	logic [31:0]           lfsr = 32'h1990c140;
	// Reference copy of every word written so far
	logic [mem_data_w-1:0] shadow [int];
	logic [mem_addr_w-1:0] pool [8];
	int                    cycle = 0;
	int                    checks = 0;
	int                    errors = 0;
	int                    tests = 0;
	int                    test_start = 0;
	// Access in flight
	logic                  exp_fetch = 1'b0;
	logic                  exp_known = 1'b0;
	logic [mem_data_w-1:0] exp_data = '0;
	int                    acc_cycle = 0;
	// From acceptance through the done cycle
	logic                  busy = 1'b0;
	// Load/store goes first after reset
	logic                  last_fetch = 1'b1;

	mem_subsystem dut (.*);

	bind mem_subsystem mem_subsystem_properties u_properties (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.rsp_done    (rsp_done),
		.fetch_done  (fetch_done),
		.fetch_instr (fetch_instr),
		.ls_done     (ls_done),
		.ls_rdata    (ls_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycle++;
		if (cycle > cycle_limit) begin
			$display("Timeout after %0d cycles, a response never arrived", cycle);
			$display("Finished with errors");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[62:0], lfsr[0]};
		end
	endtask

	task automatic compare_word(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_quiet_outputs();
		compare_word("ls_done", 64'(1'b0), 64'(ls_done));
		compare_word("fetch_done", 64'(1'b0), 64'(fetch_done));
		compare_word("ls_rdata", '0, ls_rdata);
		compare_word("fetch_instr", '0, 64'(fetch_instr));
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("Test %0s finished with %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// One load/store access, returns in its done cycle
	task automatic ls_access(input logic wr, input logic [mem_addr_w-1:0] addr,
			input logic [mem_data_w-1:0] wdata);
		@(posedge clk);
		#2;
		ls_valid = 1'b1;
		ls_write = wr;
		ls_addr  = addr;
		ls_wdata = wdata;
		// Held until granted
		@(negedge clk);
		while (!ls_ready) @(negedge clk);
		@(posedge clk);
		#2;
		ls_valid = 1'b0;
		ls_write = 1'b0;
		while (!ls_done) @(negedge clk);
	endtask

	task automatic fetch_access(input logic [fetch_addr_w-1:0] addr);
		@(posedge clk);
		#2;
		fetch_valid = 1'b1;
		fetch_addr  = addr;
		@(negedge clk);
		while (!fetch_ready) @(negedge clk);
		@(posedge clk);
		#2;
		fetch_valid = 1'b0;
		while (!fetch_done) @(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// Response monitor
	//////////////////////////////////////////////////

	// Sampled mid-cycle, inputs move just after the rising edge
	always @(negedge clk) begin
		mem_word_u word;
		logic      grant_fetch;
		logic      grant_ls;
		if (rst) begin
			// Nothing granted while busy, ties go to last loser
			grant_fetch = !busy && (!ls_valid || !last_fetch);
			grant_ls    = !busy && (!fetch_valid || last_fetch);
			if (fetch_valid) begin
				compare_word("fetch_ready", 64'(grant_fetch), 64'(fetch_ready));
			end
			if (ls_valid) begin
				compare_word("ls_ready", 64'(grant_ls), 64'(ls_ready));
			end
			if (fetch_done || ls_done) begin
				checks++;
				assert (fetch_done == exp_fetch) else begin
					errors++;
					$display("Done went to the client that does not own the access");
				end
				compare_word("done latency", 64'(6), 64'(cycle - acc_cycle));
				if (exp_known && fetch_done) begin
					compare_word("fetch_instr", exp_data, 64'(fetch_instr));
				end
				if (exp_known && ls_done) compare_word("ls_rdata", exp_data, ls_rdata);
				busy = 1'b0;
			end
			if ((fetch_valid && fetch_ready) || (ls_valid && ls_ready)) begin
				exp_fetch = fetch_ready;
				exp_known = 1'b0;
				exp_data  = '0;
				acc_cycle = cycle;
				busy      = 1'b1;
				if (fetch_ready && shadow.exists(int'(fetch_addr[fetch_addr_w-1:1]))) begin
					// Half picked by bit 0 of the instruction address
					word.dword = shadow[int'(fetch_addr[fetch_addr_w-1:1])];
					exp_data   = 64'(word.instr[fetch_addr[0]]);
					exp_known  = 1'b1;
				end
				if (ls_ready && shadow.exists(int'(ls_addr))) begin
					exp_data  = shadow[int'(ls_addr)];
					exp_known = 1'b1;
				end
				// Write takes effect after the old word is read
				if (ls_ready && ls_write) shadow[int'(ls_addr)] = ls_wdata;
				if (fetch_valid && ls_valid) begin
					checks++;
					assert (fetch_ready != last_fetch) else begin
						errors++;
						$display("Contention granted the same client twice in a row");
					end
				end
				last_fetch = fetch_ready;
			end
		end
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial begin
		logic [63:0] v;
		logic [63:0] d;
		rst         = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		ls_valid    = 1'b0;
		ls_write    = 1'b0;
		ls_addr     = '0;
		ls_wdata    = '0;
		#1 rst = 1'b0;
		repeat (reset_cycles - 1) @(posedge clk);
		@(negedge clk);
		check_quiet_outputs();
		@(posedge clk);
		#2 rst = 1'b1;
		@(negedge clk);
		check_quiet_outputs();
		report_test("reset");

		for (int i = 0; i < 8; i++) begin
			take_bits(mem_addr_w, v);
			pool[i] = v[mem_addr_w-1:0];
			take_bits(mem_data_w, d);
			ls_access(1'b1, pool[i], d);
			ls_access(1'b0, pool[i], '0);
		end
		report_test("write_read");

		for (int i = 0; i < 8; i++) begin
			take_bits(mem_data_w, d);
			ls_access(1'b1, pool[i], d);
		end
		report_test("write_returns_old");

		for (int i = 0; i < 8; i++) begin
			fetch_access({pool[i], 1'b0});
			fetch_access({pool[i], 1'b1});
		end
		report_test("fetch_halves");

		// Both clients keep asking back to back
		fork
			for (int i = 0; i < 8; i++) begin
				take_bits(3, v);
				take_bits(mem_data_w, d);
				ls_access(1'b1, pool[v[2:0]], d);
			end
			for (int i = 0; i < 8; i++) begin
				fetch_access({pool[i], i[0]});
			end
		join
		report_test("contention");

		// Bit 4 client, bit 3 write or half, bits 2:0 pool slot
		for (int n = 0; n < 40; n++) begin
			take_bits(5, v);
			d = '0;
			if (v[4]) begin
				fetch_access({pool[v[2:0]], v[3]});
			end else begin
				if (v[3]) take_bits(mem_data_w, d);
				ls_access(v[3], pool[v[2:0]], d);
			end
		end
		report_test("random_traffic");

		repeat (2) @(posedge clk);
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* build.f */
source/mem_pkg.sv
source/data_memory.sv
source/memory_interface.sv
source/port_arbiter.sv
source/mem_subsystem.sv
verif/mem_subsystem_properties.sv
verif/mem_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module mem_subsystem_tb
output=$(./obj_dir/Vmem_subsystem_tb || true)
printf '%s\n' "$output"
# Pass only if the pass line was printed
printf '%s\n' "$output" | grep -q "Finished with no errors"
